//--- include/spinn_link_cfg.svh
// SpiNNaker link transmitter constants
// packet word is always 72 bits wide; a short packet only uses the low 40
// nibble counts must stay consistent with the packet width

`ifndef SPINN_LINK_CFG_SVH
`define SPINN_LINK_CFG_SVH

// --------------------------------------------------
// packet format
// --------------------------------------------------
`define SPINN_PKT_BITS       72  // header + key + payload

// data symbols per packet, end-of-packet not counted
`define SPINN_SHORT_NIBBLES  10  // header + key
`define SPINN_LONG_NIBBLES   18  // header + key + payload

// --------------------------------------------------
// link interface
// --------------------------------------------------
// flops on the async acknowledge wire
`define SPINN_SYNC_STAGES    2

`endif

//--- hw/spinn_link_pkg.sv
// types shared by the link transmitter blocks
// nibble array view assumes SPINN_PKT_BITS == 4 * SPINN_LONG_NIBBLES
// header bit 1 selects long packets, as on the SpiNNaker link

`include "spinn_link_cfg.svh"

package spinn_link_pkg;

  // --------------------------------------------------
  // link level types
  // --------------------------------------------------
  typedef logic [3:0] nibble_t;  // one data symbol worth of packet
  typedef logic [6:0] symbol_t;  // state of the 7 link wires

  // --------------------------------------------------
  // packet word
  // --------------------------------------------------
  // same 72 bits seen two ways:
  //   fields  -> header decode (size flag)
  //   nibbles -> serialization, nibble 0 is bits 3:0
  //
  //  71        40 39        8 7      0
  // +------------+-----------+--------+
  // |  payload   |    key    | header |
  // +------------+-----------+--------+
  //
  typedef union packed {
    struct packed {
      logic [31:0] payload;  // only sent for long packets
      logic [31:0] key;      // routing key
      logic [7:0]  header;   // bit 1 = payload present
    } fields;
    nibble_t [`SPINN_LONG_NIBBLES - 1:0] nibbles;  // lsn first on the wire
  } pkt_word_u;

endpackage

//--- hw/pkt_serializer.sv
// packet to nibble serializer
// holds one packet; a new one is taken only after the previous eop flit left
// data must be stable while pkt_vld is high and pkt_rdy low

`timescale 1ns/1ns
`include "spinn_link_cfg.svh"

module pkt_serializer (
  input  logic                      CLK_IN,
  input  logic                      RESET_IN,

  // packet port
  input  spinn_link_pkg::pkt_word_u pkt_data,
  input  logic                      pkt_vld,
  output logic                      pkt_rdy,

  // flit port
  output spinn_link_pkg::nibble_t   flt_nibble,
  output logic                      flt_eop,
  output logic                      flt_vld,
  input  logic                      flt_rdy
);

  import spinn_link_pkg::*;

  // --------------------------------------------------
  // constants
  // --------------------------------------------------
  localparam logic IDLE_ST = 1'b0;  // waiting for a packet
  localparam logic TRAN_ST = 1'b1;  // nibbles / eop going out

  localparam logic [4:0] SHORT_LAST = 5'(`SPINN_SHORT_NIBBLES - 1);
  localparam logic [4:0] LONG_LAST  = 5'(`SPINN_LONG_NIBBLES - 1);

  // --------------------------------------------------
  // internal signals
  // --------------------------------------------------
  logic      state;     // idle / transmit
  pkt_word_u pkt_buf;   // packet shifted one nibble per flit
  logic      long_pkt;  // header bit 1 of buffered packet
  logic[4:0] nib_cnt;   // data nibbles already handed out
  logic      pkt_acc;   // packet taken this cycle
  logic      flt_xfer;  // flit taken this cycle
  logic      last_nib;  // flit in flight is the final data nibble

  assign pkt_rdy  = (state == IDLE_ST);  // drops on the accepting edge
  assign flt_vld  = (state == TRAN_ST);  // valid from the cycle after
  assign pkt_acc  = pkt_vld & pkt_rdy;
  assign flt_xfer = flt_vld & flt_rdy;

  // nibble 0 of the buffer is always the one on offer
  assign flt_nibble = pkt_buf.nibbles[0];

  assign last_nib = (nib_cnt == (long_pkt ? LONG_LAST : SHORT_LAST));

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      state <= IDLE_ST;
    end else begin
      case (state)
        IDLE_ST: if (pkt_acc) state <= TRAN_ST;                // start new packet
        TRAN_ST: if (flt_xfer && flt_eop) state <= IDLE_ST;   // eop gone so back to idle
        default: state <= IDLE_ST;
      endcase
    end
  end

  // --------------------------------------------------
  // packet buffer
  // --------------------------------------------------
  // packet word and size flag loaded on accept
  always_ff @(posedge CLK_IN) begin
    if (pkt_acc) begin
      pkt_buf  <= pkt_data;
      long_pkt <= pkt_data.fields.header[1];  // size from header
    end else if (flt_xfer && !flt_eop) begin
      // drop the nibble just sent so the next one moves to slot 0
      pkt_buf.nibbles <= {nibble_t'(4'h0),
                          pkt_buf.nibbles[`SPINN_LONG_NIBBLES - 1:1]};
    end
  end

  // --------------------------------------------------
  // nibble counter and eop flag
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      nib_cnt <= 5'd0;
    end else if (pkt_acc) begin
      nib_cnt <= 5'd0;              // fresh packet
    end else if (flt_xfer && !flt_eop) begin
      nib_cnt <= nib_cnt + 5'd1;    // one more nibble gone
    end
  end

  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      flt_eop <= 1'b0;
    end else if (pkt_acc) begin
      flt_eop <= 1'b0;              // first flit is always data
    end else if (flt_xfer) begin
      // eop follows the last data nibble and nothing follows eop
      flt_eop <= !flt_eop && last_nib;
    end
  end

endmodule

//--- hw/nrz_2of7_encoder.sv
// NRZ 2-of-7 encoder for the SpiNNaker link
// every load toggles exactly two wires; the wires are never returned to zero
// symbol is registered and drives the link wires directly

`timescale 1ns/1ns

module nrz_2of7_encoder (
  input  logic                    CLK_IN,
  input  logic                    RESET_IN,
  input  logic                    sym_load,    // step the wires this cycle
  input  spinn_link_pkg::nibble_t flt_nibble,
  input  logic                    flt_eop,
  output spinn_link_pkg::symbol_t symbol
);

  import spinn_link_pkg::*;

  symbol_t code;  // wires to toggle for the current flit

  // --------------------------------------------------
  // 2-of-7 code table
  // --------------------------------------------------
  always_comb begin
    if (flt_eop) begin
      code = 7'b1100000;                  // eop, wires 6 and 5
    end else begin
      case (flt_nibble)
        4'h0:    code = 7'b0010001;
        4'h1:    code = 7'b0010010;
        4'h2:    code = 7'b0010100;
        4'h3:    code = 7'b0011000;
        4'h4:    code = 7'b0100001;
        4'h5:    code = 7'b0100010;
        4'h6:    code = 7'b0100100;
        4'h7:    code = 7'b0101000;
        4'h8:    code = 7'b1000001;
        4'h9:    code = 7'b1000010;
        4'ha:    code = 7'b1000100;
        4'hb:    code = 7'b1001000;
        4'hc:    code = 7'b0000011;     // low pairs, no wire 4..6
        4'hd:    code = 7'b0000110;
        4'he:    code = 7'b0001100;
        default: code = 7'b0001001;     // 4'hf
      endcase
    end
  end

  // --------------------------------------------------
  // link wire register
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      symbol <= '0;                       // link idles with all wires low
    end else if (sym_load) begin
      symbol <= symbol ^ code;            // nrz, toggle the pair
    end
  end

endmodule

//--- hw/link_tx_handshake.sv
// link flow control, one symbol per acknowledge transition
// sl_ack is asynchronous and goes through a SPINN_SYNC_STAGES flop chain
// ack latency to flt_rdy is two to three clocks after the wire toggles

`timescale 1ns/1ns
`include "spinn_link_cfg.svh"

module link_tx_handshake (
  input  logic CLK_IN,
  input  logic RESET_IN,

  // flit port
  input  logic flt_vld,
  output logic flt_rdy,

  // to encoder
  output logic sym_load,   // one-cycle pulse per accepted flit

  // async link ack
  input  logic sl_ack
);

  // --------------------------------------------------
  // internal signals
  // --------------------------------------------------
  logic [`SPINN_SYNC_STAGES - 1:0] ack_sync;  // sync chain, msb is output
  logic ack_s;      // synchronized ack level
  logic ack_seen;   // ack level at last completed symbol
  logic waiting;    // symbol out, ack not back yet
  logic acked;      // ack transition seen

  assign ack_s = ack_sync[`SPINN_SYNC_STAGES - 1];
  assign acked = (ack_s != ack_seen);

  // flow control towards the serializer
  assign flt_rdy  = !waiting;
  assign sym_load = flt_vld && flt_rdy;

  // --------------------------------------------------
  // ack synchronizer
  // --------------------------------------------------
  // both ack_sync and ack_seen reset low so no phantom ack after reset
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      ack_sync <= '0;
    end else begin
      ack_sync <= {ack_sync[`SPINN_SYNC_STAGES - 2:0], sl_ack};  // shift in
    end
  end

  // --------------------------------------------------
  // waiting flag and last seen ack level
  // --------------------------------------------------
  always_ff @(posedge CLK_IN or posedge RESET_IN) begin
    if (RESET_IN) begin
      waiting  <= 1'b0;
      ack_seen <= 1'b0;
    end else if (sym_load) begin
      waiting <= 1'b1;             // new symbol on the wires
    end else if (waiting && acked) begin
      waiting  <= 1'b0;            // receiver took it
      ack_seen <= ack_s;           // toggle consumed
    end
  end

  // a toggle arriving while idle is kept pending in ack_s vs ack_seen
  // and completes the next symbol immediately

endmodule

//--- hw/spinn_link_sender.sv
// SpiNNaker link transmitter, top level
// one symbol in flight per acknowledge toggle, no burst mode and no error outputs
// SL_ACK_IN may be fully asynchronous to CLK_IN

`timescale 1ns/1ns

module spinn_link_sender (
  input  logic                     CLK_IN,
  input  logic                     RESET_IN,

  // synchronous packet port
  input  spinn_link_pkg::pkt_word_u PKT_DATA_IN,
  input  logic                     PKT_VLD_IN,
  output logic                     PKT_RDY_OUT,

  // asynchronous SpiNNaker link
  output spinn_link_pkg::symbol_t  SL_DATA_2OF7_OUT,
  input  logic                     SL_ACK_IN
);

  import spinn_link_pkg::*;

  // --------------------------------------------------
  // flit port, serializer -> handshake/encoder
  // --------------------------------------------------
  nibble_t flt_nibble;  // current data nibble
  logic    flt_eop;     // current flit is end-of-packet
  logic    flt_vld;
  logic    flt_rdy;
  logic    sym_load;    // flit accepted, encoder steps

  pkt_serializer ps (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .pkt_data   (PKT_DATA_IN),
    .pkt_vld    (PKT_VLD_IN),
    .pkt_rdy    (PKT_RDY_OUT),
    .flt_nibble (flt_nibble),
    .flt_eop    (flt_eop),
    .flt_vld    (flt_vld),
    .flt_rdy    (flt_rdy)
  );

  // link wire state
  nrz_2of7_encoder enc (
    .CLK_IN     (CLK_IN),
    .RESET_IN   (RESET_IN),
    .sym_load   (sym_load),
    .flt_nibble (flt_nibble),
    .flt_eop    (flt_eop),
    .symbol     (SL_DATA_2OF7_OUT)
  );

  // ack sync + one-symbol flow control
  link_tx_handshake hs (
    .CLK_IN   (CLK_IN),
    .RESET_IN (RESET_IN),
    .flt_vld  (flt_vld),
    .flt_rdy  (flt_rdy),
    .sym_load (sym_load),
    .sl_ack   (SL_ACK_IN)
  );

endmodule

//--- tests/tb_spinn_link_sender.sv
// testbench for the SpiNNaker link transmitter
// link receiver model acks every symbol after 0..ack_delay_max clocks
// outputs sampled on falling edges and inputs driven on rising edges

`timescale 1ns/1ns
`include "spinn_link_cfg.svh"

module tb_spinn_link_sender;

  import spinn_link_pkg::*;

  localparam int         PKT_TIMEOUT  = 2000;  // clocks per packet accept
  localparam int         IDLE_TIMEOUT = 4000;  // clocks for the link to drain
  localparam logic [4:0] EOP_VAL      = 5'h10; // decoded end-of-packet
  localparam logic [4:0] BAD_VAL      = 5'h1f; // not a valid 2-of-7 step

  // DUT inputs with their start values
  logic      CLK_IN      = 1'b0;
  logic      RESET_IN    = 1'b1;
  pkt_word_u PKT_DATA_IN = '0;
  logic      PKT_VLD_IN  = 1'b0;
  logic      SL_ACK_IN   = 1'b0;
  logic      PKT_RDY_OUT;
  symbol_t   SL_DATA_2OF7_OUT;

  // receiver model state
  symbol_t      prev_sym      = '0;
  logic [4:0]   rx_q[$];            // decoded symbols in arrival order
  int           sym_count     = 0;  // symbols seen on the wires
  int           ack_count     = 0;  // acks given back
  int           ack_wait      = 0;  // clocks before the next ack
  int           ack_delay_max = 12;
  logic [31:0]  ack_seed      = 32'hf9800572;

  // stimulus and bookkeeping
  pkt_word_u    tx_q[$];
  logic [4:0]   exp_q[$];
  int           rx_base       = 0;  // first rx_q entry of the current test
  int           overlaps      = 0;  // accepts with the last eop still unacked
  logic [31:0]  stim_seed     = 32'hf9800572;
  int           chk_errors    = 0;
  int           mon_errors    = 0;
  int           tests_run     = 0;
  int           tests_failed  = 0;
  string        cur_test      = "reset_state";

  spinn_link_sender uut (
    .CLK_IN           (CLK_IN),
    .RESET_IN         (RESET_IN),
    .PKT_DATA_IN      (PKT_DATA_IN),
    .PKT_VLD_IN       (PKT_VLD_IN),
    .PKT_RDY_OUT      (PKT_RDY_OUT),
    .SL_DATA_2OF7_OUT (SL_DATA_2OF7_OUT),
    .SL_ACK_IN        (SL_ACK_IN)
  );

  always #50 CLK_IN = ~CLK_IN;  // 100 ns period

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] seed);
    return seed * 32'd1664525 + 32'd1013904223;
  endfunction

  // maps the toggled wire pair to a nibble or to eop on wires 6 and 5
  function automatic logic [4:0] decode_sym(input symbol_t diff);
    case (diff)
      7'h11: return 5'h00;
      7'h12: return 5'h01;
      7'h14: return 5'h02;
      7'h18: return 5'h03;
      7'h21: return 5'h04;
      7'h22: return 5'h05;
      7'h24: return 5'h06;
      7'h28: return 5'h07;
      7'h41: return 5'h08;
      7'h42: return 5'h09;
      7'h44: return 5'h0a;
      7'h48: return 5'h0b;
      7'h03: return 5'h0c;
      7'h06: return 5'h0d;
      7'h0c: return 5'h0e;
      7'h09: return 5'h0f;
      7'h60: return EOP_VAL;
      default: return BAD_VAL;
    endcase
  endfunction

  function automatic int total_errors();
    return chk_errors + mon_errors;
  endfunction

  task automatic check_value(input string test, input string what,
                             input int expected, input int actual);
    assert (expected == actual) else begin
      $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h",
               test, what, expected, actual);
      chk_errors++;
    end
  endtask

  task automatic random_packet(input logic long_pkt, output pkt_word_u pkt);
    stim_seed = lcg_next(stim_seed);
    pkt.fields.payload = stim_seed;        // junk for short packets
    stim_seed = lcg_next(stim_seed);
    pkt.fields.key = stim_seed;
    stim_seed = lcg_next(stim_seed);
    pkt.fields.header = stim_seed[31:24];
    pkt.fields.header[1] = long_pkt;       // size flag
  endtask

  // expected symbols from the bit layout with lsn first and eop last
  task automatic queue_expected(input pkt_word_u pkt);
    logic [`SPINN_PKT_BITS - 1:0] word;
    int                           n;
    int                           i;
    word = pkt;
    n = word[1] ? `SPINN_LONG_NIBBLES : `SPINN_SHORT_NIBBLES;
    for (i = 0; i < n; i++) begin
      exp_q.push_back({1'b0, word[4 * i +: 4]});
    end
    exp_q.push_back(EOP_VAL);
  endtask

  // --------------------------------------------------
  // packet source that offers the next packet right away
  // --------------------------------------------------
  task automatic drive_packets(input string test);
    int   idx;
    int   guard;
    logic take;
    idx = 0;
    guard = 0;
    overlaps = 0;
    @(posedge CLK_IN);
    PKT_DATA_IN <= tx_q[0];
    PKT_VLD_IN  <= 1'b1;
    while (idx < tx_q.size() && guard < PKT_TIMEOUT) begin
      @(negedge CLK_IN);
      take = PKT_VLD_IN && PKT_RDY_OUT;  // transfer on the coming edge
      @(posedge CLK_IN);
      guard++;
      if (take) begin
        // previous eop still on the wires without an ack
        if (rx_q.size() > 0 && rx_q[$] == EOP_VAL && sym_count != ack_count) begin
          overlaps++;
        end
        idx++;
        guard = 0;
        if (idx < tx_q.size()) begin
          PKT_DATA_IN <= tx_q[idx];
        end else begin
          PKT_VLD_IN <= 1'b0;
        end
      end
    end
    assert (idx == tx_q.size()) else begin
      $display("Timeout in %s: packet %0d was never accepted", test, idx);
      chk_errors++;
      PKT_VLD_IN <= 1'b0;
    end
  endtask

  // all expected symbols out and the last one acked
  task automatic wait_link_idle(input string test);
    int   guard;
    logic done;
    guard = 0;
    done = 1'b0;
    while (!done && guard < IDLE_TIMEOUT) begin
      @(posedge CLK_IN);
      guard++;
      done = (rx_q.size() >= rx_base + exp_q.size()) && (ack_count == sym_count);
    end
    assert (done) else begin
      $display("Timeout in %s: only %0d of %0d symbols arrived", test,
               rx_q.size() - rx_base, exp_q.size());
      chk_errors++;
    end
  endtask

  task automatic compare_rx(input string test);
    int n_rx;
    int i;
    n_rx = rx_q.size() - rx_base;
    check_value(test, "symbol count", exp_q.size(), n_rx);
    for (i = 0; i < exp_q.size() && i < n_rx; i++) begin
      check_value(test, $sformatf("symbol %0d", i),
                  int'(exp_q[i]), int'(rx_q[rx_base + i]));
    end
    rx_base = rx_q.size();
  endtask

  // send tx_q and check everything that comes out
  task automatic send_and_check(input string test, input int max_delay);
    int i;
    cur_test = test;
    ack_delay_max = max_delay;
    exp_q.delete();
    for (i = 0; i < tx_q.size(); i++) begin
      queue_expected(tx_q[i]);
    end
    drive_packets(test);
    wait_link_idle(test);
    compare_rx(test);
  endtask

  task automatic end_test(input string test, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %s passed", test);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test, errs);
    end
  endtask

  // --------------------------------------------------
  // link receiver model
  // --------------------------------------------------
  always @(negedge CLK_IN) begin : rx_monitor
    symbol_t    diff;
    logic [4:0] val;
    if (RESET_IN) begin
      prev_sym = SL_DATA_2OF7_OUT;
    end else if (SL_DATA_2OF7_OUT !== prev_sym) begin
      diff = SL_DATA_2OF7_OUT ^ prev_sym;
      assert ($countones(diff) == 2) else begin
        $display("Mismatch %s toggled wires: expected 2, actual %0d",
                 cur_test, $countones(diff));
        mon_errors++;
      end
      // a new symbol only after the last one was acked
      assert (sym_count == ack_count) else begin
        $display("Link wires changed in %s before symbol %0d was acknowledged",
                 cur_test, sym_count - 1);
        mon_errors++;
      end
      val = decode_sym(diff);
      rx_q.push_back(val);
      sym_count++;
      prev_sym = SL_DATA_2OF7_OUT;
    end
  end

  // one ack toggle per symbol after a random delay
  always @(posedge CLK_IN) begin : ack_responder
    if (ack_count != sym_count) begin
      if (ack_wait == 0) begin
        SL_ACK_IN <= ~SL_ACK_IN;
        ack_count <= ack_count + 1;
        ack_seed = lcg_next(ack_seed);
        ack_wait <= int'(ack_seed[23:8]) % (ack_delay_max + 1);
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  initial begin : main
    pkt_word_u pkt;
    int        i;
    int        errs_before;

    // reset state during and after reset
    errs_before = total_errors();
    for (i = 0; i < 5; i++) begin
      @(negedge CLK_IN);
      check_value("reset_state", "PKT_RDY_OUT", 1, int'(PKT_RDY_OUT));
      check_value("reset_state", "SL_DATA_2OF7_OUT", 0, int'(SL_DATA_2OF7_OUT));
    end
    @(posedge CLK_IN);
    RESET_IN <= 1'b0;
    for (i = 0; i < 2; i++) begin
      @(negedge CLK_IN);
      check_value("reset_state", "PKT_RDY_OUT", 1, int'(PKT_RDY_OUT));
      check_value("reset_state", "SL_DATA_2OF7_OUT", 0, int'(SL_DATA_2OF7_OUT));
    end
    end_test("reset_state", errs_before);

    // short packet with header bit 1 clear
    errs_before = total_errors();
    tx_q.delete();
    random_packet(1'b0, pkt);
    tx_q.push_back(pkt);
    send_and_check("short_packet", 12);
    end_test("short_packet", errs_before);

    // long packet with header bit 1 set
    errs_before = total_errors();
    tx_q.delete();
    random_packet(1'b1, pkt);
    tx_q.push_back(pkt);
    send_and_check("long_packet", 12);
    end_test("long_packet", errs_before);

    // every nibble value once plus eop
    errs_before = total_errors();
    tx_q.delete();
    pkt.fields.payload = 32'hfedcba98;
    pkt.fields.key     = 32'h76543210;
    pkt.fields.header  = 8'h02;
    tx_q.push_back(pkt);
    send_and_check("two_of_seven", 12);
    end_test("two_of_seven", errs_before);

    // slow receiver so the monitor sees the wires hold
    errs_before = total_errors();
    tx_q.delete();
    random_packet(1'b1, pkt);
    tx_q.push_back(pkt);
    random_packet(1'b0, pkt);
    tx_q.push_back(pkt);
    send_and_check("flow_control", 40);
    end_test("flow_control", errs_before);

    // twenty packets of random size without gaps
    errs_before = total_errors();
    tx_q.delete();
    for (i = 0; i < 20; i++) begin
      stim_seed = lcg_next(stim_seed);
      random_packet(stim_seed[20], pkt);
      tx_q.push_back(pkt);
    end
    send_and_check("back_to_back", 12);
    check_value("back_to_back", "accepts during eop ack", 19, overlaps);
    end_test("back_to_back", errs_before);

    $display("tests run %0d, failed %0d, errors %0d",
             tests_run, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
hw/spinn_link_pkg.sv
hw/pkt_serializer.sv
hw/nrz_2of7_encoder.sv
hw/link_tx_handshake.sv
hw/spinn_link_sender.sv
tests/tb_spinn_link_sender.sv

//--- run_sim.sh
#!/bin/sh
# build and run the link transmitter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_spinn_link_sender \
  -f compile.f \
  -o tb_sim

./obj_dir/tb_sim > sim.log
cat sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
